/* sim.f */
source/ooo_pkg.sv
source/add_sub_decode.sv
source/add_sub_station.sv
source/add_sub_alu.sv
source/add_sub.sv
dv/add_sub_chk.sv
dv/add_sub_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the add_sub testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module add_sub_tb \
	-f sim.f \
	-o sim_add_sub

# The run may stop with a non-zero status; the log decides the outcome
./obj_dir/sim_add_sub > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

/* dv/add_sub_tb.sv */
`timescale 1ns/1ps

module add_sub_tb;

	localparam int RS_DEPTH = 4;
	localparam int N_DIRECTED = 17;
	localparam int N_RANDOM = 200;
	localparam int MAX_CYCLES = 40 * (N_DIRECTED + N_RANDOM) + 200;
	localparam logic [31:0] IDLE_WORD = 32'hffffffff;

	logic clk;
	logic rst_n;
	ooo_pkg::inst_word_t inst;
	ooo_pkg::operand_t read0;
	ooo_pkg::operand_t read1;
	logic [ooo_pkg::ROB_WIDTH-1:0] new_tag;
	ooo_pkg::cdb_t cdb;
	logic req_ready;
	logic issue_ready;
	ooo_pkg::result_t req;

	integer seed = 84646;
	int cycles;
	int ready_mode;
	int n_issued;
	int n_done;
	logic bus_random;
	ooo_pkg::cdb_t no_bus;

	// Reference model indexed by tag
	// Tags 0..7 are ours and 8..15 stand for other units
	logic exp_valid [16];
	logic [31:0] exp_data [16];
	logic ext_busy [16];
	logic [31:0] ext_val [16];
	logic [3:0] bcast_q [$];

	add_sub #(
		.RS_DEPTH (RS_DEPTH)
	) u_add_sub (
		.clk         (clk),
		.rst_n       (rst_n),
		.inst        (inst),
		.read0       (read0),
		.read1       (read1),
		.new_tag     (new_tag),
		.cdb         (cdb),
		.req_ready   (req_ready),
		.issue_ready (issue_ready),
		.req         (req)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_result(input ooo_pkg::result_t got, input ooo_pkg::result_t exp,
		input string what);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED at %0t: %s got v=%0b tag=%0d data=%h, %s",
				$time, what, got.valid, got.tag, got.data,
				$sformatf("exp v=%0b tag=%0d data=%h", exp.valid, exp.tag, exp.data)));
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_run($sformatf("CHECK FAILED at %0t: %s issue_ready=%b, expected %b",
				$time, what, got, exp));
		end
	endtask

	function automatic logic is_imm(input ooo_pkg::op_e op);
		return op inside {ooo_pkg::OP_ADDI, ooo_pkg::OP_SUBI, ooo_pkg::OP_SL2ADDI};
	endfunction

	function automatic logic [31:0] expected_value(input ooo_pkg::op_e op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			ooo_pkg::OP_SUB, ooo_pkg::OP_SUBI: return a - b;
			ooo_pkg::OP_SL2ADD, ooo_pkg::OP_SL2ADDI: return {a[29:0], 2'b00} + b;
			default: return a + b;
		endcase
	endfunction

	function automatic ooo_pkg::operand_t present(input logic [31:0] data);
		return '{valid: 1'b1, tag: 4'd0, data: data};
	endfunction

	function automatic ooo_pkg::operand_t waiting(input logic [3:0] tag);
		return '{valid: 1'b0, tag: tag, data: 32'd0};
	endfunction

	function automatic logic any_pending();
		logic busy;
		busy = bcast_q.size() > 0;
		for (int k = 0; k < 16; k++) begin
			busy = busy || exp_valid[k];
		end
		return busy;
	endfunction

	// Other units broadcast their awaited results, at random times in the stream test
	task automatic bus_pop();
		logic [3:0] t;
		if (bcast_q.size() > 0 && (!bus_random || ($random(seed) & 1) == 1)) begin
			t = bcast_q.pop_front();
			cdb = '{valid: 1'b1, tag: t, data: ext_val[t]};
			ext_busy[t] = 1'b0;
		end else begin
			cdb = '0;
		end
	endtask

	task automatic tick(input ooo_pkg::cdb_t force_bus);
		@(negedge clk);
		inst = IDLE_WORD;
		read0 = '0;
		read1 = '0;
		new_tag = '0;
		if (force_bus.valid && issue_ready) begin
			cdb = force_bus;
		end else begin
			bus_pop();
		end
	endtask

	task automatic alloc_ext(output logic [3:0] t, output logic ok);
		ok = 1'b0;
		t = 4'd0;
		for (int k = 8; k < 16; k++) begin
			if (!ext_busy[k] && !ok) begin
				t = 4'(k);
				ok = 1'b1;
			end
		end
		if (ok) begin
			ext_busy[t] = 1'b1;
			ext_val[t] = $random(seed);
		end
	endtask

	task automatic wait_idle();
		while (any_pending() || req.valid) begin
			tick(no_bus);
		end
	endtask

	task automatic issue_op(input ooo_pkg::op_e op, input ooo_pkg::operand_t a,
		input ooo_pkg::operand_t b, input logic [15:0] imm, input ooo_pkg::cdb_t force_bus);
		logic [3:0] t;
		logic found;
		ooo_pkg::inst_word_t w;
		logic [31:0] va;
		logic [31:0] vb;
		found = 1'b0;
		t = 4'd0;
		while (!found) begin
			for (int k = 0; k < 8; k++) begin
				if (!exp_valid[k] && !found) begin
					t = 4'(k);
					found = 1'b1;
				end
			end
			if (!found) begin
				tick(no_bus);
			end
		end
		w = '0;
		w.i.op = op;
		w.i.rd = 5'($random(seed));
		w.i.rs = 5'($random(seed));
		w.i.imm = imm;
		// A full station drops the offer, so keep it up until issue_ready is high
		tick(force_bus);
		while (!issue_ready) begin
			tick(force_bus);
		end
		inst = w;
		read0 = a;
		read1 = b;
		new_tag = t;
		va = a.valid ? a.data : ext_val[a.tag];
		vb = is_imm(op) ? {{16{imm[15]}}, imm} : (b.valid ? b.data : ext_val[b.tag]);
		exp_valid[t] = 1'b1;
		exp_data[t] = expected_value(op, va, vb);
		n_issued++;
		if (!a.valid) begin
			if (force_bus.valid && force_bus.tag == a.tag) ext_busy[a.tag] = 1'b0;
			else bcast_q.push_back(a.tag);
		end
		if (!is_imm(op) && !b.valid) begin
			if (force_bus.valid && force_bus.tag == b.tag) ext_busy[b.tag] = 1'b0;
			else bcast_q.push_back(b.tag);
		end
	endtask

	task automatic retire_request();
		ooo_pkg::result_t exp;
		if (!exp_valid[req.tag]) begin
			fail_run($sformatf("Request with tag %0d arrived at %0t with nothing in flight",
				req.tag, $time));
		end
		exp = '{valid: 1'b1, tag: req.tag, data: exp_data[req.tag]};
		check_result(req, exp, "retired result");
		exp_valid[req.tag] = 1'b0;
		n_done++;
	endtask

	task automatic test_all_ops();
		issue_op(ooo_pkg::OP_ADD, present(32'd5), present(32'd7), 16'd0, no_bus);
		issue_op(ooo_pkg::OP_ADDI, present(32'd100), present(32'hdead), 16'hfffd, no_bus);
		issue_op(ooo_pkg::OP_SUB, present(32'd3), present(32'd10), 16'd0, no_bus);
		issue_op(ooo_pkg::OP_SUBI, present(32'd1), present(32'd0), 16'h8000, no_bus);
		issue_op(ooo_pkg::OP_SL2ADD, present(32'h40000001), present(32'd2), 16'd0, no_bus);
		issue_op(ooo_pkg::OP_SL2ADDI, present(32'd7), present(32'd0), 16'hffff, no_bus);
		issue_op(ooo_pkg::OP_ADD, present(32'hffffffff), present(32'd1), 16'd0, no_bus);
		issue_op(ooo_pkg::OP_SUB, present($random(seed)), present($random(seed)), 16'd0, no_bus);
		wait_idle();
	endtask

	task automatic test_waiting_operands();
		logic [3:0] t;
		logic ok;
		ooo_pkg::cdb_t now_bus;
		alloc_ext(t, ok);
		issue_op(ooo_pkg::OP_ADD, waiting(t), present(32'd9), 16'd0, no_bus);
		wait_idle();
		alloc_ext(t, ok);
		now_bus = '{valid: 1'b1, tag: t, data: ext_val[t]};
		issue_op(ooo_pkg::OP_SUB, present(32'd50), waiting(t), 16'd0, now_bus);
		wait_idle();
		alloc_ext(t, ok);
		issue_op(ooo_pkg::OP_SL2ADDI, waiting(t), present(32'd0), 16'hfff0, no_bus);
		wait_idle();
	endtask

	task automatic test_foreign_opcode();
		ready_mode = 1;
		// Codes just past the six and then the all-ones word, offered back to back
		// Were they taken, the station would fill while the request is held
		for (int k = 0; k <= RS_DEPTH; k++) begin
			tick(no_bus);
			if (k < RS_DEPTH) begin
				inst = {6'(6 + k), IDLE_WORD[25:0]};
			end else begin
				inst = IDLE_WORD;
			end
			read0 = present(32'(k));
			read1 = present(32'd2);
			new_tag = 4'(k);
		end
		tick(no_bus);
		check_ready(issue_ready, 1'b1, "after foreign opcodes");
		ready_mode = 0;
		// Any request now is flagged by the monitor as having no instruction in flight
		repeat (10) tick(no_bus);
	endtask

	task automatic test_back_pressure();
		ooo_pkg::result_t first;
		ready_mode = 1;
		for (int k = 0; k <= RS_DEPTH; k++) begin
			issue_op(ooo_pkg::OP_ADDI, present($random(seed)), present(32'd0), 16'(k), no_bus);
		end
		tick(no_bus);
		check_ready(issue_ready, 1'b0, "station full under back-pressure");
		first = req;
		repeat (4) tick(no_bus);
		check_result(req, first, "held request");
		ready_mode = 0;
		wait_idle();
		check_ready(issue_ready, 1'b1, "after drain");
	endtask

	task automatic test_random_stream();
		ooo_pkg::op_e op;
		ooo_pkg::operand_t a;
		ooo_pkg::operand_t b;
		logic [3:0] t;
		logic ok;
		bus_random = 1'b1;
		ready_mode = 2;
		for (int n = 0; n < N_RANDOM; n++) begin
			op = ooo_pkg::op_e'($unsigned($random(seed)) % 6);
			a = present($random(seed));
			b = present($random(seed));
			if (($random(seed) & 3) == 0) begin
				alloc_ext(t, ok);
				if (ok) a = waiting(t);
			end
			if (!is_imm(op) && ($random(seed) & 3) == 0) begin
				alloc_ext(t, ok);
				if (ok) b = waiting(t);
			end
			issue_op(op, a, b, 16'($random(seed)), no_bus);
		end
		wait_idle();
		ready_mode = 0;
	endtask

	// Arbiter model that retires the request on each edge where it drives ready
	initial begin
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			if (ready_mode == 0) req_ready = 1'b1;
			else if (ready_mode == 1) req_ready = 1'b0;
			else req_ready = ($random(seed) & 3) != 0;
			if (req_ready && req.valid) begin
				retire_request();
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > MAX_CYCLES) begin
				fail_run($sformatf("Timeout after %0d cycles with results still missing",
					cycles));
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		inst = IDLE_WORD;
		read0 = '0;
		read1 = '0;
		new_tag = '0;
		cdb = '0;
		req_ready = 1'b0;
		no_bus = '0;
		ready_mode = 0;
		bus_random = 1'b0;
		n_issued = 0;
		n_done = 0;
		for (int k = 0; k < 16; k++) begin
			exp_valid[k] = 1'b0;
			exp_data[k] = '0;
			ext_busy[k] = 1'b0;
			ext_val[k] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_ready(issue_ready, 1'b1, "after reset");
		test_all_ops();
		test_waiting_operands();
		test_foreign_opcode();
		test_back_pressure();
		test_random_stream();
		repeat (5) tick(no_bus);
		if (n_done == n_issued && !any_pending()) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_run($sformatf("Only %0d of %0d results came back", n_done, n_issued));
		end
	end

endmodule

/* dv/add_sub_chk.sv */
`timescale 1ns/1ps

module add_sub_chk #(
	parameter int RS_DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  ooo_pkg::result_t  req,
	input  logic              req_ready,
	input  logic              issue_ready,
	input  logic              mine,
	input  logic              take
);

	// Station occupancy counted from accepted issues and dispatches
	int occ;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			occ <= 0;
		end else if (mine && issue_ready && !take) begin
			occ <= occ + 1;
		end else if (take && !(mine && issue_ready)) begin
			occ <= occ - 1;
		end
	end

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		req.valid && !req_ready |=> req.valid && $stable(req.tag) && $stable(req.data))
		else $error("Request changed while it was waiting for the arbiter");

	a_reset_values: assert property (@(posedge clk)
		!rst_n |-> !req.valid && issue_ready)
		else $error("Request valid or issue ready wrong during reset");

	a_ready_vs_count: assert property (@(posedge clk) disable iff (!rst_n)
		issue_ready == (occ < RS_DEPTH))
		else $error("Issue ready does not match the station occupancy");

endmodule

bind add_sub add_sub_chk #(
	.RS_DEPTH (RS_DEPTH)
) u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.req         (req),
	.req_ready   (req_ready),
	.issue_ready (issue_ready),
	.mine        (mine),
	.take        (take)
);

/* source/add_sub.sv */
`timescale 1ns/1ps

module add_sub #(
	parameter int RS_DEPTH = 4
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  ooo_pkg::inst_word_t            inst,
	input  ooo_pkg::operand_t              read0,
	input  ooo_pkg::operand_t              read1,
	input  logic [ooo_pkg::ROB_WIDTH-1:0]  new_tag,
	input  ooo_pkg::cdb_t                  cdb,
	input  logic                           req_ready,
	output logic                           issue_ready,
	output ooo_pkg::result_t               req
);

	logic mine;
	logic full;
	logic take;
	logic pick_valid;
	ooo_pkg::issue_t entry;
	ooo_pkg::dispatch_t pick;

	add_sub_decode u_decode (
		.inst    (inst),
		.read0   (read0),
		.read1   (read1),
		.new_tag (new_tag),
		.mine    (mine),
		.entry   (entry)
	);

	add_sub_station #(
		.RS_DEPTH (RS_DEPTH)
	) u_station (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (mine),
		.entry      (entry),
		.cdb        (cdb),
		.take       (take),
		.full       (full),
		.pick       (pick),
		.pick_valid (pick_valid)
	);

	add_sub_alu u_alu (
		.clk        (clk),
		.rst_n      (rst_n),
		.pick       (pick),
		.pick_valid (pick_valid),
		.req_ready  (req_ready),
		.take       (take),
		.req        (req)
	);

	assign issue_ready = !full;

endmodule

/* source/add_sub_alu.sv */
`timescale 1ns/1ps

module add_sub_alu (
	input  logic                clk,
	input  logic                rst_n,
	input  ooo_pkg::dispatch_t  pick,
	input  logic                pick_valid,
	input  logic                req_ready,
	output logic                take,
	output ooo_pkg::result_t    req
);

	logic [ooo_pkg::DATA_WIDTH-1:0] result;

	logic                           req_valid;
	logic [ooo_pkg::ROB_WIDTH-1:0]  req_tag;
	logic [ooo_pkg::DATA_WIDTH-1:0] req_data;

	// The request register is free when empty or retiring at this edge
	assign take = pick_valid && (!req_valid || req_ready);

	always_comb begin
		case (pick.op)
			ooo_pkg::ALU_SUB: begin
				result = pick.a - pick.b;
			end
			ooo_pkg::ALU_SL2ADD: begin
				result = (pick.a << 2) + pick.b;
			end
			default: begin
				result = pick.a + pick.b;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
		end else if (take) begin
			req_valid <= 1'b1;
		end else if (req_ready) begin
			req_valid <= 1'b0;
		end
	end

	// Tag and data only move on a dispatch, so they hold under back-pressure
	always_ff @(posedge clk) begin
		if (take) begin
			req_tag <= pick.tag;
			req_data <= result;
		end
	end

	assign req.valid = req_valid;
	assign req.tag = req_tag;
	assign req.data = req_data;

endmodule

/* source/add_sub_station.sv */
`timescale 1ns/1ps

module add_sub_station #(
	parameter int RS_DEPTH = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue,
	input  ooo_pkg::issue_t     entry,
	input  ooo_pkg::cdb_t       cdb,
	input  logic                take,
	output logic                full,
	output ooo_pkg::dispatch_t  pick,
	output logic                pick_valid
);

	localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

	ooo_pkg::issue_t slot [RS_DEPTH];
	logic [RS_DEPTH-1:0] busy;
	logic [RS_DEPTH-1:0] ready_vec;

	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] pick_idx;
	logic accept;
	ooo_pkg::issue_t incoming;

	// Returns the operand with its value filled in if the bus carries its tag
	function automatic ooo_pkg::operand_t snoop(
		input ooo_pkg::operand_t opnd,
		input ooo_pkg::cdb_t bus
	);
		ooo_pkg::operand_t res;
		res = opnd;
		if (!opnd.valid && bus.valid && (bus.tag == opnd.tag)) begin
			res.valid = 1'b1;
			res.data = bus.data;
		end
		return res;
	endfunction

	assign full = &busy;
	assign accept = issue && !full;

	// A broadcast in the issue cycle itself is caught here
	always_comb begin
		incoming = entry;
		incoming.a = snoop(entry.a, cdb);
		incoming.b = snoop(entry.b, cdb);
	end

	// Lowest free slot, scanned downward so the smallest index wins
	always_comb begin
		free_idx = '0;
		for (int k = RS_DEPTH - 1; k >= 0; k--) begin
			if (!busy[k]) begin
				free_idx = IDX_W'(k);
			end
		end
	end

	always_comb begin
		for (int k = 0; k < RS_DEPTH; k++) begin
			ready_vec[k] = busy[k] && slot[k].a.valid && slot[k].b.valid;
		end
	end

	always_comb begin
		pick_idx = '0;
		for (int k = RS_DEPTH - 1; k >= 0; k--) begin
			if (ready_vec[k]) begin
				pick_idx = IDX_W'(k);
			end
		end
	end

	assign pick_valid = |ready_vec;

	always_comb begin
		pick.op = slot[pick_idx].op;
		pick.a = slot[pick_idx].a.data;
		pick.b = slot[pick_idx].b.data;
		pick.tag = slot[pick_idx].tag;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			if (take) begin
				busy[pick_idx] <= 1'b0;
			end
			// The picked slot is busy, so it is never the free one
			if (accept) begin
				busy[free_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < RS_DEPTH; k++) begin
			slot[k].a <= snoop(slot[k].a, cdb);
			slot[k].b <= snoop(slot[k].b, cdb);
		end
		if (accept) begin
			slot[free_idx] <= incoming;
		end
	end

endmodule

/* source/add_sub_decode.sv */
`timescale 1ns/1ps

module add_sub_decode (
	input  ooo_pkg::inst_word_t            inst,
	input  ooo_pkg::operand_t              read0,
	input  ooo_pkg::operand_t              read1,
	input  logic [ooo_pkg::ROB_WIDTH-1:0]  new_tag,
	output logic                           mine,
	output ooo_pkg::issue_t                entry
);

	localparam int EXT_W = ooo_pkg::DATA_WIDTH - 16;

	logic imm_form;
	logic [ooo_pkg::DATA_WIDTH-1:0] imm_ext;

	assign imm_ext = {{EXT_W{inst.i.imm[15]}}, inst.i.imm};

	always_comb begin
		mine = 1'b1;
		imm_form = 1'b0;
		entry.op = ooo_pkg::ALU_ADD;
		case (inst.r.op)
			ooo_pkg::OP_ADD: begin
				entry.op = ooo_pkg::ALU_ADD;
			end
			ooo_pkg::OP_ADDI: begin
				entry.op = ooo_pkg::ALU_ADD;
				imm_form = 1'b1;
			end
			ooo_pkg::OP_SUB: begin
				entry.op = ooo_pkg::ALU_SUB;
			end
			ooo_pkg::OP_SUBI: begin
				entry.op = ooo_pkg::ALU_SUB;
				imm_form = 1'b1;
			end
			ooo_pkg::OP_SL2ADD: begin
				entry.op = ooo_pkg::ALU_SL2ADD;
			end
			ooo_pkg::OP_SL2ADDI: begin
				entry.op = ooo_pkg::ALU_SL2ADD;
				imm_form = 1'b1;
			end
			// Opcodes of the other units
			default: mine = 1'b0;
		endcase

		entry.a = read0;
		entry.b = read1;
		entry.tag = new_tag;

		// Immediate forms never wait on source B
		if (imm_form) begin
			entry.b.valid = 1'b1;
			entry.b.tag = '0;
			entry.b.data = imm_ext;
		end
	end

endmodule

/* source/ooo_pkg.sv */
package ooo_pkg;

	// Tag width follows the reorder buffer size of the core
	localparam int ROB_WIDTH = 4;
	localparam int DATA_WIDTH = 32;

	typedef enum logic [5:0] {
		OP_ADD     = 6'd0,
		OP_ADDI    = 6'd1,
		OP_SUB     = 6'd2,
		OP_SUBI    = 6'd3,
		OP_SL2ADD  = 6'd4,
		OP_SL2ADDI = 6'd5
	} op_e;

	typedef struct packed {
		op_e        op;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [10:0] unused;
	} r_fmt_t;

	typedef struct packed {
		op_e         op;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [15:0] imm;
	} i_fmt_t;

	// The opcode lines up in both views, so either can be used to read it
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_word_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SL2ADD
	} alu_op_e;

	// With valid low, tag names the producer that is still awaited
	typedef struct packed {
		logic                  valid;
		logic [ROB_WIDTH-1:0]  tag;
		logic [DATA_WIDTH-1:0] data;
	} operand_t;

	typedef struct packed {
		logic                  valid;
		logic [ROB_WIDTH-1:0]  tag;
		logic [DATA_WIDTH-1:0] data;
	} cdb_t;

	typedef struct packed {
		alu_op_e              op;
		operand_t             a;
		operand_t             b;
		logic [ROB_WIDTH-1:0] tag;
	} issue_t;

	typedef struct packed {
		alu_op_e               op;
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		logic [ROB_WIDTH-1:0]  tag;
	} dispatch_t;

	typedef struct packed {
		logic                  valid;
		logic [ROB_WIDTH-1:0]  tag;
		logic [DATA_WIDTH-1:0] data;
	} result_t;

endpackage
